// File: bench/pongTb.sv
`timescale 1ns/10ps
`default_nettype none

module pongTb;

	import pongVideoPkg::*;
	import pongGamePkg::*;

	localparam int BallDiv = 4;
	localparam int PaddleDiv = 8;
	localparam int SkipLines = 60; // Lands well inside the visible frame
	localparam int BlankLen = int'(HSyncLen) + int'(HBackPorch);

	logic ClockDoPixel;
	logic arstN;
	logic paddle1DownN;
	logic paddle1UpN;
	logic paddle2DownN;
	logic paddle2UpN;
	logic newGame;
	colour_t red;
	colour_t green;
	colour_t blue;
	logic hSyncN;
	logic vSyncN;
	segments_t score1Seg;
	segments_t score2Seg;

	string testName;
	int modelX;
	int modelY;
	logic modelUp;
	logic modelLeft;
	score_t expScore1;
	score_t expScore2;

	pongTop #(.BallTickDiv(BallDiv), .PaddleTickDiv(PaddleDiv)) i_pongTop (.*);

	always #20 ClockDoPixel = ~ClockDoPixel;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkColour(input string what, input colour_t exp, input colour_t act);
		if (act !== exp)
			abortRun($sformatf("** Error %s, %s: expected %h, actual %h",
				testName, what, exp, act));
	endtask

	task automatic checkSegments(input string what, input segments_t exp,
		input segments_t act);
		if (act !== exp)
			abortRun($sformatf("** Error %s, %s: expected %b, actual %b",
				testName, what, exp, act));
	endtask

	task automatic checkLevel(input string what, input logic exp, input logic act);
		if (act !== exp)
			abortRun($sformatf("** Error %s, %s: expected %b, actual %b",
				testName, what, exp, act));
	endtask

	task automatic checkPixel(input string what, input colour_t exp);
		checkColour({what, " red"}, exp, red);
		checkColour({what, " green"}, exp, green);
		checkColour({what, " blue"}, exp, blue);
	endtask

	// Returns at the first sample that shows hSyncN low after high
	task automatic waitHSyncFall();
		logic prev;
		int count;
		prev = hSyncN;
		count = 0;
		@(negedge ClockDoPixel);
		while (!(prev && !hSyncN)) begin
			if (count == 2 * int'(HTotal))
				abortRun("No falling edge of hSyncN came within two lines");
			prev = hSyncN;
			@(negedge ClockDoPixel);
			count++;
		end
	endtask

	task automatic waitScoreChange(input int limit);
		segments_t last1;
		segments_t last2;
		int count;
		last1 = score1Seg;
		last2 = score2Seg;
		count = 0;
		while (score1Seg === last1 && score2Seg === last2) begin
			if (count == limit)
				abortRun($sformatf("The score did not change within %0d cycles in %s",
					limit, testName));
			@(negedge ClockDoPixel);
			count++;
		end
	endtask

	// Ball rules with both paddles parked at home
	task automatic predictGoal(output int scorer, output int ticks);
		int r;
		logic wall;
		logic paddle;
		r = BallRadius;
		scorer = 0;
		ticks = 0;
		while (scorer == 0) begin
			if (ticks == 100000)
				abortRun("The ball model found no goal within 100000 ball ticks");
			ticks++;
			wall = modelUp ? (modelY - r <= FieldTop) : (modelY + r >= FieldBottom);
			paddle = (modelY > PaddleHome) && (modelY < PaddleHome + PaddleHeight)
				&& (modelLeft ? (modelX - r <= Paddle1X + PaddleWidth)
				: (modelX + r >= Paddle2X));
			if (wall)
				modelUp = !modelUp;
			else if (paddle)
				modelLeft = !modelLeft;
			else if (modelX - r <= GoalLeft || modelX + r >= GoalRight) begin
				scorer = (modelX - r <= GoalLeft) ? 2 : 1;
				modelX = BallServeX; // Direction is kept
				modelY = BallServeY;
			end else begin
				modelX = modelLeft ? modelX - 1 : modelX + 1;
				modelY = modelUp ? modelY - 1 : modelY + 1;
			end
		end
	endtask

	task automatic awaitGoal();
		int scorer;
		int ticks;
		predictGoal(scorer, ticks);
		if (scorer == 1)
			expScore1++;
		else
			expScore2++;
		if (expScore1 == WinScore || expScore2 == WinScore) begin
			expScore1 = '0; // Match over
			expScore2 = '0;
		end
		waitScoreChange((ticks + 4) * BallDiv + 64);
		checkSegments("score1Seg", SegDigits[expScore1], score1Seg);
		checkSegments("score2Seg", SegDigits[expScore2], score2Seg);
	endtask

	task automatic applyReset();
		testName = "after reset";
		arstN = 1'b0;
		repeat (10) @(negedge ClockDoPixel);
		checkSegments("score1Seg", SegDigits[0], score1Seg);
		checkSegments("score2Seg", SegDigits[0], score2Seg);
		checkLevel("hSyncN", 1'b1, hSyncN);
		checkLevel("vSyncN", 1'b1, vSyncN);
		checkPixel("colour", '0);
		arstN = 1'b1;
	endtask

	task automatic measureLines();
		int line;
		int k;
		testName = "line timing";
		repeat (SkipLines) waitHSyncFall();
		for (line = 0; line < 3; line++) begin
			for (k = 0; k < int'(HTotal); k++) begin
				checkLevel("hSyncN", k >= int'(HSyncLen), hSyncN);
				checkLevel("vSyncN", 1'b1, vSyncN);
				if (k < BlankLen)
					checkPixel("blanked colour", '0);
				@(negedge ClockDoPixel);
			end
		end
		checkLevel("hSyncN at the fourth line", 1'b0, hSyncN);
	endtask

	task automatic probeBorder();
		testName = "border and blanking";
		waitHSyncFall();
		repeat (BlankLen) @(negedge ClockDoPixel);
		checkPixel("left border pixel", ColourFull);
		repeat (int'(HVisible)) @(negedge ClockDoPixel);
		checkPixel("pixel past the line end", '0);
	endtask

	task automatic playFirstGoal();
		testName = "first goal";
		newGame = 1'b1;
		repeat (4) @(negedge ClockDoPixel);
		newGame = 1'b0;
		checkSegments("score1Seg", SegDigits[0], score1Seg);
		checkSegments("score2Seg", SegDigits[0], score2Seg);
		modelX = BallParkX;
		modelY = BallParkY;
		modelUp = 1'b1; // upRight
		modelLeft = 1'b0;
		expScore1 = '0;
		expScore2 = '0;
		awaitGoal();
	endtask

	task automatic playToMatchEnd();
		testName = "end of match";
		do begin
			awaitGoal();
		end while (expScore1 != '0 || expScore2 != '0);
	endtask

	always @(negedge ClockDoPixel)
		if (i_pongTop.iProps.failCount != 0)
			abortRun("A bound sync or blanking assertion failed");

	initial begin
		ClockDoPixel = 1'b0;
		arstN = 1'b0;
		paddle1DownN = 1'b1;
		paddle1UpN = 1'b1;
		paddle2DownN = 1'b1;
		paddle2UpN = 1'b1;
		newGame = 1'b0;
		applyReset();
		measureLines();
		probeBorder();
		playFirstGoal();
		playToMatchEnd();
		if (i_pongTop.iProps.failCount == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else
			abortRun("A bound sync or blanking assertion failed");
	end

endmodule

`default_nettype wire

// File: bench/pongTop_props.sv
`timescale 1ns/10ps
`default_nettype none

module pongTopProps (
	input logic ClockDoPixel,
	input logic arstN,
	input logic hSyncN,
	input pongVideoPkg::colour_t red,
	input pongVideoPkg::colour_t green,
	input pongVideoPkg::colour_t blue
);

	import pongVideoPkg::*;

	int lowCount;
	int sinceFall;
	logic hPrev;
	logic seenFall;
	int failCount = 0;

	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN) begin
			lowCount <= 0;
			sinceFall <= 0;
			hPrev <= 1'b1;
			seenFall <= 1'b0;
		end else begin
			lowCount <= hSyncN ? 0 : lowCount + 1;
			hPrev <= hSyncN;
			sinceFall <= (hPrev && !hSyncN) ? 1 : sinceFall + 1; // Restart at each fall
			if (hPrev && !hSyncN)
				seenFall <= 1'b1;
		end
	end

	syncLen: assert property (@(posedge ClockDoPixel) disable iff (!arstN)
		$rose(hSyncN) |-> lowCount == int'(HSyncLen))
		else begin
			$error("hSyncN low phase is not HSyncLen cycles long");
			failCount++;
		end

	linePeriod: assert property (@(posedge ClockDoPixel) disable iff (!arstN)
		$fell(hSyncN) && seenFall |-> sinceFall == int'(HTotal))
		else begin
			$error("hSyncN falling edges are not HTotal cycles apart");
			failCount++;
		end

	syncBlank: assert property (@(posedge ClockDoPixel) disable iff (!arstN)
		!hSyncN |-> (red == '0 && green == '0 && blue == '0))
		else begin
			$error("Colour is not blanked during hSyncN");
			failCount++;
		end

endmodule

bind pongTop pongTopProps iProps (.*);

`default_nettype wire

// File: files.f
rtl/pongVideoPkg.sv
rtl/pongGamePkg.sv
rtl/vgaTiming.sv
rtl/gameTicks.sv
rtl/paddleControl.sv
rtl/ballEngine.sv
rtl/scoreKeeper.sv
rtl/frameRenderer.sv
rtl/pongTop.sv
bench/pongTop_props.sv
bench/pongTb.sv

// File: rtl/ballEngine.sv
`timescale 1ns/10ps
`default_nettype none

module ballEngine (
	input logic ClockDoPixel,
	input logic arstN,
	input logic ballTick,
	input logic newGame,
	input logic matchOver,
	input pongVideoPkg::coord_t paddle1Y,
	input pongVideoPkg::coord_t paddle2Y,
	output pongVideoPkg::coord_t ballX,
	output pongVideoPkg::coord_t ballY,
	output logic goalFor1,
	output logic goalFor2
);

	import pongVideoPkg::*;
	import pongGamePkg::*;

	ballDir_e dir;
	logic goingUp;
	logic goingLeft;
	logic hitWall;
	logic hitPaddle1;
	logic hitPaddle2;
	logic outLeft;
	logic outRight;

	assign goingUp = (dir == upRight) || (dir == upLeft);
	assign goingLeft = (dir == downLeft) || (dir == upLeft);

	// Edge of the ball against the bands
	assign hitWall = goingUp ? (ballY - BallRadius <= FieldTop)
		: (ballY + BallRadius >= FieldBottom);

	assign hitPaddle1 = goingLeft && (ballX - BallRadius <= Paddle1X + PaddleWidth)
		&& (ballY > paddle1Y) && (ballY < paddle1Y + PaddleHeight);
	assign hitPaddle2 = !goingLeft && (ballX + BallRadius >= Paddle2X)
		&& (ballY > paddle2Y) && (ballY < paddle2Y + PaddleHeight);

	assign outLeft = (ballX - BallRadius <= GoalLeft);
	assign outRight = (ballX + BallRadius >= GoalRight);

	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN) begin
			ballX <= BallParkX;
			ballY <= BallParkY;
			dir <= upRight;
			goalFor1 <= 1'b0;
			goalFor2 <= 1'b0;
		end else begin
			goalFor1 <= 1'b0;
			goalFor2 <= 1'b0;
			if (newGame) begin
				ballX <= BallParkX;
				ballY <= BallParkY;
				dir <= upRight;
			end else if (ballTick && !matchOver) begin
				if (hitWall)
					dir <= ballDir_e'(dir ^ 2'b01); // Vertical flip
				else if (hitPaddle1 || hitPaddle2)
					dir <= ballDir_e'(dir ^ 2'b11); // Horizontal flip
				else if (outLeft || outRight) begin
					ballX <= BallServeX; // Serve keeps the direction
					ballY <= BallServeY;
					goalFor2 <= outLeft;
					goalFor1 <= !outLeft;
				end else begin
					ballX <= goingLeft ? ballX - 11'd1 : ballX + 11'd1;
					ballY <= goingUp ? ballY - 11'd1 : ballY + 11'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/frameRenderer.sv
`timescale 1ns/10ps
`default_nettype none

module frameRenderer (
	input logic ClockDoPixel,
	input logic arstN,
	input pongVideoPkg::coord_t pixelX,
	input pongVideoPkg::coord_t pixelY,
	input logic visible,
	input pongVideoPkg::coord_t paddle1Y,
	input pongVideoPkg::coord_t paddle2Y,
	input pongVideoPkg::coord_t ballX,
	input pongVideoPkg::coord_t ballY,
	output pongVideoPkg::colour_t red,
	output pongVideoPkg::colour_t green,
	output pongVideoPkg::colour_t blue
);

	import pongVideoPkg::*;
	import pongGamePkg::*;

	localparam logic [22:0] BallRadiusSq = BallRadius * BallRadius;

	coord_t dx;
	coord_t dy;
	logic [22:0] distSq;
	logic inBorder;
	logic inPaddle1;
	logic inPaddle2;
	logic inBall;
	colour_t level;

	assign dx = (pixelX > ballX) ? pixelX - ballX : ballX - pixelX;
	assign dy = (pixelY > ballY) ? pixelY - ballY : ballY - pixelY;
	assign distSq = dx * dx + dy * dy;
	assign inBall = (distSq < BallRadiusSq);

	assign inBorder = (pixelX < GoalLeft) || (pixelX > GoalRight)
		|| (pixelY < FieldTop) || (pixelY > FieldBottom);
	assign inPaddle1 = (pixelX > Paddle1X) && (pixelX < Paddle1X + PaddleWidth)
		&& (pixelY > paddle1Y) && (pixelY < paddle1Y + PaddleHeight);
	assign inPaddle2 = (pixelX > Paddle2X) && (pixelX < Paddle2X + PaddleWidth)
		&& (pixelY > paddle2Y) && (pixelY < paddle2Y + PaddleHeight);

	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN)
			level <= '0;
		else if (visible && (inBorder || inPaddle1 || inPaddle2 || inBall))
			level <= ColourFull;
		else
			level <= '0; // Background and blanking
	end

	// Everything is drawn in white
	assign red = level;
	assign green = level;
	assign blue = level;

endmodule

`default_nettype wire

// File: rtl/gameTicks.sv
`timescale 1ns/10ps
`default_nettype none

module gameTicks #(
	parameter int BallTickDiv = 283000,
	parameter int PaddleTickDiv = 566000
) (
	input logic ClockDoPixel,
	input logic arstN,
	output logic ballTick,
	output logic paddleTick
);

	localparam int MaxDiv = (BallTickDiv > PaddleTickDiv) ? BallTickDiv : PaddleTickDiv;
	localparam int CountW = $clog2(MaxDiv + 1);
	localparam int Divs [2] = '{BallTickDiv, PaddleTickDiv};

	wire [1:0] ticks;

	for (genvar i = 0; i < 2; i++) begin : genDiv
		logic [CountW-1:0] count;

		assign ticks[i] = (count == CountW'(Divs[i] - 1));

		always_ff @(posedge ClockDoPixel or negedge arstN) begin
			if (!arstN)
				count <= '0;
			else if (ticks[i])
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	assign ballTick = ticks[0];
	assign paddleTick = ticks[1];

endmodule

`default_nettype wire

// File: rtl/paddleControl.sv
`timescale 1ns/10ps
`default_nettype none

module paddleControl (
	input logic ClockDoPixel,
	input logic arstN,
	input logic paddleTick,
	input logic matchOver,
	input logic newGame,
	input logic paddle1DownN,
	input logic paddle1UpN,
	input logic paddle2DownN,
	input logic paddle2UpN,
	output pongVideoPkg::coord_t paddle1Y,
	output pongVideoPkg::coord_t paddle2Y
);

	import pongVideoPkg::*;
	import pongGamePkg::*;

	coord_t paddleY [2];
	logic [1:0] downN;
	logic [1:0] upN;

	assign downN = {paddle2DownN, paddle1DownN};
	assign upN = {paddle2UpN, paddle1UpN};

	for (genvar i = 0; i < 2; i++) begin : genPaddle
		always_ff @(posedge ClockDoPixel or negedge arstN) begin
			if (!arstN)
				paddleY[i] <= PaddleHome;
			else if (newGame || matchOver)
				paddleY[i] <= PaddleHome;
			else if (paddleTick) begin
				if (!downN[i] && upN[i])
					paddleY[i] <= (paddleY[i] + PaddleStep > PaddleMaxY) ?
						PaddleMaxY : paddleY[i] + PaddleStep;
				else if (downN[i] && !upN[i])
					paddleY[i] <= (paddleY[i] < FieldTop + PaddleStep) ?
						FieldTop : paddleY[i] - PaddleStep;
			end // Both keys or none hold still
		end
	end

	assign paddle1Y = paddleY[0];
	assign paddle2Y = paddleY[1];

endmodule

`default_nettype wire

// File: rtl/pongGamePkg.sv
`default_nettype none

package pongGamePkg;

	import pongVideoPkg::*;

	// Playing field
	localparam coord_t FieldTop = 11'd128;
	localparam coord_t FieldBottom = 11'd896;
	localparam coord_t GoalLeft = 11'd160;
	localparam coord_t GoalRight = 11'd1120;

	// Paddles
	localparam coord_t Paddle1X = 11'd225;
	localparam coord_t Paddle2X = 11'd1030;
	localparam coord_t PaddleWidth = 11'd25;
	localparam coord_t PaddleHeight = 11'd125;
	localparam coord_t PaddleStep = 11'd3;
	localparam coord_t PaddleMaxY = 11'd771; // FieldBottom - PaddleHeight
	localparam coord_t PaddleHome = 11'd500;

	// Ball
	localparam coord_t BallRadius = 11'd15;
	localparam coord_t BallParkX = 11'd500;
	localparam coord_t BallParkY = 11'd500;
	localparam coord_t BallServeX = 11'd640;
	localparam coord_t BallServeY = 11'd512;

	// Left in bit 1, down where the bits differ, so a flip is an XOR
	typedef enum logic [1:0] {
		upRight = 2'd0,
		downRight = 2'd1,
		downLeft = 2'd2,
		upLeft = 2'd3
	} ballDir_e;

	typedef logic [3:0] score_t;
	typedef logic [6:0] segments_t; // Active low, g..a

	localparam score_t WinScore = 4'd10;

	localparam segments_t SegDigits [10] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
		7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000
	};

endpackage

`default_nettype wire

// File: rtl/pongTop.sv
`timescale 1ns/10ps
`default_nettype none

module pongTop #(
	parameter int BallTickDiv = 283000,
	parameter int PaddleTickDiv = 566000
) (
	input logic ClockDoPixel,
	input logic arstN,
	input logic paddle1DownN,
	input logic paddle1UpN,
	input logic paddle2DownN,
	input logic paddle2UpN,
	input logic newGame,
	output pongVideoPkg::colour_t red,
	output pongVideoPkg::colour_t green,
	output pongVideoPkg::colour_t blue,
	output logic hSyncN,
	output logic vSyncN,
	output pongGamePkg::segments_t score1Seg,
	output pongGamePkg::segments_t score2Seg
);

	import pongVideoPkg::*;

	coord_t pixelX;
	coord_t pixelY;
	coord_t paddle1Y;
	coord_t paddle2Y;
	coord_t ballX;
	coord_t ballY;
	logic visible;
	logic ballTick;
	logic paddleTick;
	logic goalFor1;
	logic goalFor2;
	logic matchOver;

	vgaTiming iVgaTiming (.ClockDoPixel, .arstN, .hSyncN, .vSyncN, .pixelX, .pixelY,
		.visible);

	gameTicks #(.BallTickDiv(BallTickDiv), .PaddleTickDiv(PaddleTickDiv)) iGameTicks (
		.ClockDoPixel, .arstN, .ballTick, .paddleTick);

	paddleControl iPaddleControl (.ClockDoPixel, .arstN, .paddleTick, .matchOver,
		.newGame, .paddle1DownN, .paddle1UpN, .paddle2DownN, .paddle2UpN,
		.paddle1Y, .paddle2Y);

	ballEngine iBallEngine (.ClockDoPixel, .arstN, .ballTick, .newGame, .matchOver,
		.paddle1Y, .paddle2Y, .ballX, .ballY, .goalFor1, .goalFor2);

	scoreKeeper iScoreKeeper (.ClockDoPixel, .arstN, .newGame, .goalFor1, .goalFor2,
		.matchOver, .score1Seg, .score2Seg);

	frameRenderer iFrameRenderer (.ClockDoPixel, .arstN, .pixelX, .pixelY, .visible,
		.paddle1Y, .paddle2Y, .ballX, .ballY, .red, .green, .blue);

endmodule

`default_nettype wire

// File: rtl/pongVideoPkg.sv
`default_nettype none

package pongVideoPkg;

	typedef logic [10:0] coord_t;
	typedef logic [7:0] colour_t;

	// SXGA line, in pixel clocks
	localparam coord_t HTotal = 11'd1688;
	localparam coord_t HVisible = 11'd1280;
	localparam coord_t HSyncLen = 11'd112;
	localparam coord_t HBackPorch = 11'd248;

	// SXGA frame, in lines
	localparam coord_t VTotal = 11'd1066;
	localparam coord_t VVisible = 11'd1024;
	localparam coord_t VSyncLen = 11'd3;
	localparam coord_t VBackPorch = 11'd38;

	localparam colour_t ColourFull = 8'hFF;

endpackage

`default_nettype wire

// File: rtl/scoreKeeper.sv
`timescale 1ns/10ps
`default_nettype none

module scoreKeeper (
	input logic ClockDoPixel,
	input logic arstN,
	input logic newGame,
	input logic goalFor1,
	input logic goalFor2,
	output logic matchOver,
	output pongGamePkg::segments_t score1Seg,
	output pongGamePkg::segments_t score2Seg
);

	import pongGamePkg::*;

	score_t score1;
	score_t score2;
	score_t next1;
	score_t next2;
	logic winReached;

	assign next1 = score1 + score_t'(goalFor1);
	assign next2 = score2 + score_t'(goalFor2);
	assign winReached = (next1 == WinScore) || (next2 == WinScore);

	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN) begin
			score1 <= '0;
			score2 <= '0;
			matchOver <= 1'b0;
		end else begin
			matchOver <= 1'b0;
			if (newGame) begin
				score1 <= '0;
				score2 <= '0;
			end else if (winReached) begin
				score1 <= '0; // Match over, start again
				score2 <= '0;
				matchOver <= 1'b1;
			end else begin
				score1 <= next1;
				score2 <= next2;
			end
		end
	end

	// Scores stay within 0..9
	assign score1Seg = SegDigits[score1];
	assign score2Seg = SegDigits[score2];

endmodule

`default_nettype wire

// File: rtl/vgaTiming.sv
`timescale 1ns/10ps
`default_nettype none

module vgaTiming (
	input logic ClockDoPixel,
	input logic arstN,
	output logic hSyncN,
	output logic vSyncN,
	output pongVideoPkg::coord_t pixelX,
	output pongVideoPkg::coord_t pixelY,
	output logic visible
);

	import pongVideoPkg::*;

	coord_t hCount;
	coord_t vCount;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == HTotal - 11'd1);
	assign frameEnd = (vCount == VTotal - 11'd1);

	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			hCount <= lineEnd ? '0 : hCount + 11'd1;
			if (lineEnd)
				vCount <= frameEnd ? '0 : vCount + 11'd1; // Next line
		end
	end

	// One cycle behind the counts, like the colour register
	always_ff @(posedge ClockDoPixel or negedge arstN) begin
		if (!arstN) begin
			hSyncN <= 1'b1;
			vSyncN <= 1'b1;
		end else begin
			hSyncN <= (hCount >= HSyncLen);
			vSyncN <= (vCount >= VSyncLen);
		end
	end

	assign pixelX = hCount - (HSyncLen + HBackPorch);
	assign pixelY = vCount - (VSyncLen + VBackPorch);

	// Counts before the back porch wrap far above the visible range
	assign visible = (pixelX < HVisible) && (pixelY < VVisible);

endmodule

`default_nettype wire
